// ==== all.f ====
dbg_pkg.sv
uart_rx.sv
uart_tx.sv
uart_word_link.sv
debug_unit.sv
debug_top.sv
tb_debug_top.sv

// ==== dbg_pkg.sv ====
`default_nettype none

package dbg_pkg;

    // Dump sequencer states
    typedef enum logic [2:0] {
        dump_idle,
        dump_pc,
        dump_regs,
        dump_mem,
        dump_latch,
        dump_wait,
        dump_done
    } dump_state_t;

    // Program loader states
    typedef enum logic {
        load_active,
        load_done
    } load_state_t;

    // Pipeline stage codes, upper bits of the latch select
    typedef enum logic [2:0] {
        stage_fetch   = 3'd0,
        stage_decode  = 3'd1,
        stage_execute = 3'd2,
        stage_memory  = 3'd3,
        stage_wb      = 3'd4
    } stage_t;

    // Latch fields per stage, fixed by the processor
    localparam logic [3:0] n_fetch_fields   = 4'd2;
    localparam logic [3:0] n_decode_fields  = 4'd6;
    localparam logic [3:0] n_execute_fields = 4'd6;
    localparam logic [3:0] n_memory_fields  = 4'd4;
    localparam logic [3:0] n_wb_fields      = 4'd2;

    localparam int n_latch_fields = int'(n_fetch_fields) + int'(n_decode_fields)
                                  + int'(n_execute_fields) + int'(n_memory_fields)
                                  + int'(n_wb_fields);

    localparam int word_width = 32;

    // The all-zero word is the halt instruction
    localparam logic [word_width-1:0] halt_word = '0;

endpackage

`default_nettype wire

// ==== debug_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module debug_top import dbg_pkg::*; #(
    parameter int clks_per_bit     = 868,
    parameter int num_regs         = 32,
    parameter int num_mem_words    = 20,
    parameter int instr_addr_width = 10
) (
    input  wire                         clk,
    input  wire                         rst,
    input  wire                         rx,
    input  wire  [word_width-1:0]       pc,
    input  wire  [word_width-1:0]       reg_data,
    input  wire  [word_width-1:0]       mem_data,
    input  wire  [word_width-1:0]       latch_data,
    output logic                        tx,
    output logic [word_width-1:0]       debug_addr,
    output logic [6:0]                  latch_sel,
    output logic                        debug_active,
    output logic                        stall_pc,
    output logic                        instr_we,
    output logic [instr_addr_width-1:0] instr_addr,
    output logic [word_width-1:0]       instr_data
);

    // Word-level link between sequencer and UART
    logic [word_width-1:0] rx_word;
    logic                  rx_word_valid;
    logic [word_width-1:0] tx_word;
    logic                  tx_word_start;
    logic                  tx_word_done;

    uart_word_link #(
        .clks_per_bit (clks_per_bit)
    ) i_link (
        .clk           (clk),
        .rst           (rst),
        .rx            (rx),
        .tx            (tx),
        .rx_word       (rx_word),
        .rx_word_valid (rx_word_valid),
        .tx_word       (tx_word),
        .tx_word_start (tx_word_start),
        .tx_word_done  (tx_word_done)
    );

    debug_unit #(
        .num_regs         (num_regs),
        .num_mem_words    (num_mem_words),
        .instr_addr_width (instr_addr_width)
    ) i_debug_unit (
        .clk           (clk),
        .rst           (rst),
        .rx_word       (rx_word),
        .rx_word_valid (rx_word_valid),
        .tx_word_done  (tx_word_done),
        .pc            (pc),
        .reg_data      (reg_data),
        .mem_data      (mem_data),
        .latch_data    (latch_data),
        .tx_word       (tx_word),
        .tx_word_start (tx_word_start),
        .debug_addr    (debug_addr),
        .latch_sel     (latch_sel),
        .debug_active  (debug_active),
        .stall_pc      (stall_pc),
        .instr_we      (instr_we),
        .instr_addr    (instr_addr),
        .instr_data    (instr_data)
    );

endmodule

`default_nettype wire

// ==== debug_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module debug_unit import dbg_pkg::*; #(
    parameter int num_regs         = 32,
    parameter int num_mem_words    = 20,
    parameter int instr_addr_width = 10
) (
    input  wire                         clk,
    input  wire                         rst,
    input  wire  [word_width-1:0]       rx_word,
    input  wire                         rx_word_valid,
    input  wire                         tx_word_done,
    input  wire  [word_width-1:0]       pc,
    input  wire  [word_width-1:0]       reg_data,
    input  wire  [word_width-1:0]       mem_data,
    input  wire  [word_width-1:0]       latch_data,
    output logic [word_width-1:0]       tx_word,
    output logic                        tx_word_start,
    output logic [word_width-1:0]       debug_addr,
    output logic [6:0]                  latch_sel,
    output logic                        debug_active,
    output logic                        stall_pc,
    output logic                        instr_we,
    output logic [instr_addr_width-1:0] instr_addr,
    output logic [word_width-1:0]       instr_data
);

    load_state_t                 load_state;
    logic [instr_addr_width-1:0] load_addr;

    dump_state_t dump_state;
    dump_state_t next_state;
    stage_t      stage;
    logic [3:0]  field;
    logic [4:0]  latch_cnt;

    function automatic logic [3:0] stage_fields(input stage_t s);
        case (s)
            stage_fetch:   return n_fetch_fields;
            stage_decode:  return n_decode_fields;
            stage_execute: return n_execute_fields;
            stage_memory:  return n_memory_fields;
            default:       return n_wb_fields;
        endcase
    endfunction

    //////////////////////////////
    // Program loader
    //////////////////////////////
    assign instr_addr = load_addr;

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            load_state <= load_active;
            load_addr  <= '0;
            instr_we   <= 1'b0;
        end
        else
        begin
            instr_we <= 1'b0;
            // Advance once the current word has been written
            if (instr_we)
                load_addr <= load_addr + 1'b1;
            if (load_state == load_active && rx_word_valid)
            begin
                instr_we <= 1'b1;
                if (rx_word == halt_word || load_addr == {instr_addr_width{1'b1}})
                    load_state <= load_done;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (load_state == load_active && rx_word_valid)
            instr_data <= rx_word;
    end

    //////////////////////////////
    // Dump sequencer
    //////////////////////////////
    assign latch_sel     = {stage, field};
    assign tx_word_start = dump_state inside {dump_pc, dump_regs, dump_mem, dump_latch};

    always_comb
    begin
        case (dump_state)
            dump_pc:   tx_word = pc;
            dump_regs: tx_word = reg_data;
            dump_mem:  tx_word = mem_data;
            default:   tx_word = latch_data;
        endcase
    end

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            dump_state   <= dump_idle;
            next_state   <= dump_idle;
            debug_addr   <= '0;
            stage        <= stage_fetch;
            field        <= '0;
            latch_cnt    <= '0;
            debug_active <= 1'b0;
            stall_pc     <= 1'b1;
        end
        else
        begin
            case (dump_state)
                dump_idle:
                begin
                    // Requests only count once the program is in
                    if (load_state == load_done && rx_word_valid)
                    begin
                        debug_active <= 1'b1;
                        stall_pc     <= 1'b1;
                        debug_addr   <= '0;
                        stage        <= stage_fetch;
                        field        <= '0;
                        latch_cnt    <= '0;
                        dump_state   <= dump_pc;
                    end
                end
                dump_pc:
                begin
                    next_state <= dump_regs;
                    dump_state <= dump_wait;
                end
                dump_regs:
                begin
                    dump_state <= dump_wait;
                    if (debug_addr == word_width'(num_regs - 1))
                    begin
                        debug_addr <= '0;
                        next_state <= dump_mem;
                    end
                    else
                    begin
                        debug_addr <= debug_addr + 1'b1;
                        next_state <= dump_regs;
                    end
                end
                dump_mem:
                begin
                    dump_state <= dump_wait;
                    if (debug_addr == word_width'(num_mem_words - 1))
                    begin
                        debug_addr <= '0;
                        next_state <= dump_latch;
                    end
                    else
                    begin
                        debug_addr <= debug_addr + 1'b1;
                        next_state <= dump_mem;
                    end
                end
                dump_latch:
                begin
                    dump_state <= dump_wait;
                    next_state <= dump_latch;
                    latch_cnt  <= latch_cnt + 5'd1;
                    if (field == stage_fields(stage) - 4'd1)
                    begin
                        field <= '0;
                        stage <= stage_t'(stage + 3'd1);
                    end
                    else
                        field <= field + 4'd1;
                    // Last field of write-back
                    if (latch_cnt == 5'(n_latch_fields - 1))
                    begin
                        stage      <= stage_fetch;
                        next_state <= dump_done;
                    end
                end
                dump_wait:
                begin
                    if (tx_word_done)
                    begin
                        dump_state <= next_state;
                        if (next_state == dump_done)
                        begin
                            debug_active <= 1'b0;
                            stall_pc     <= 1'b0;
                        end
                    end
                end
                default:
                begin
                    latch_cnt  <= '0;
                    dump_state <= dump_idle;
                end
            endcase
        end
    end

    assert property (@(posedge clk) disable iff (rst)
        !(dump_state == dump_regs && debug_addr >= word_width'(num_regs)) &&
        !(dump_state == dump_mem && debug_addr >= word_width'(num_mem_words)))
        else $error("debug_unit: debug_addr beyond section limit");

    // Each word goes out only after the previous one has completed
    assert property (@(posedge clk) disable iff (rst)
        tx_word_start |=> !tx_word_start until_with tx_word_done)
        else $error("debug_unit: word issued before previous tx_word_done");

endmodule

`default_nettype wire

// ==== tb_debug_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_debug_top import dbg_pkg::*; ();

    localparam int clks_per_bit     = 8;
    localparam int num_regs         = 32;
    localparam int num_mem_words    = 20;
    localparam int instr_addr_width = 10;
    localparam int dump_len         = 1 + num_regs + num_mem_words + n_latch_fields;
    localparam int latch_base       = 1 + num_regs + num_mem_words;
    localparam int load_len         = 13;

    logic        clk = 1'b0;
    logic        rst;
    logic        rx;
    logic [31:0] pc;
    logic [31:0] reg_data;
    logic [31:0] mem_data;
    logic [31:0] latch_data;

    wire                        tx;
    wire [31:0]                 debug_addr;
    wire [6:0]                  latch_sel;
    wire                        debug_active;
    wire                        stall_pc;
    wire                        instr_we;
    wire [instr_addr_width-1:0] instr_addr;
    wire [31:0]                 instr_data;

    // Processor model state
    logic [31:0] pc_val;
    logic [31:0] regs [num_regs];
    logic [31:0] mem_words [num_mem_words];
    logic [31:0] latch_tab [128];
    logic [31:0] lfsr_state;

    logic [31:0]                 got_q [$];
    logic [31:0]                 exp_q [$];
    logic [31:0]                 sent_q [$];
    logic [instr_addr_width-1:0] wr_addr_q [$];
    logic [31:0]                 wr_data_q [$];
    logic [6:0]                  sel_q [$];
    logic                        act_q [$];

    int err_count  = 0;
    int fail_count = 0;
    bit timed_out  = 1'b0;

    always #50 clk = ~clk;

    debug_top #(
        .clks_per_bit     (clks_per_bit),
        .num_regs         (num_regs),
        .num_mem_words    (num_mem_words),
        .instr_addr_width (instr_addr_width)
    ) i_dut (
        .clk          (clk),
        .rst          (rst),
        .rx           (rx),
        .pc           (pc),
        .reg_data     (reg_data),
        .mem_data     (mem_data),
        .latch_data   (latch_data),
        .tx           (tx),
        .debug_addr   (debug_addr),
        .latch_sel    (latch_sel),
        .debug_active (debug_active),
        .stall_pc     (stall_pc),
        .instr_we     (instr_we),
        .instr_addr   (instr_addr),
        .instr_data   (instr_data)
    );

    // Read ports answer in the same cycle
    assign pc         = pc_val;
    assign reg_data   = (debug_addr < num_regs) ? regs[debug_addr] : 32'h0;
    assign mem_data   = (debug_addr < num_mem_words) ? mem_words[debug_addr] : 32'h0;
    assign latch_data = latch_tab[latch_sel];

    //////////////////////////////
    // Random source and model fill
    //////////////////////////////
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic take_bits(input int n, output logic [31:0] value);
        value = '0;
        for (int i = 0; i < n; i++)
        begin
            lfsr_state = lfsr_next(lfsr_state);
            value = {value[30:0], lfsr_state[0]};
        end
    endtask

    task automatic fill_model();
        logic [31:0] v;
        take_bits(32, pc_val);
        for (int i = 0; i < num_regs; i++)
        begin
            take_bits(32, v);
            regs[i] = v;
        end
        for (int i = 0; i < num_mem_words; i++)
        begin
            take_bits(32, v);
            mem_words[i] = v;
        end
        for (int i = 0; i < 128; i++)
        begin
            take_bits(32, v);
            latch_tab[i] = v;
        end
    endtask

    //////////////////////////////
    // Reference model
    //////////////////////////////
    function automatic int field_count(input int s);
        case (s)
            0:       return int'(n_fetch_fields);
            1:       return int'(n_decode_fields);
            2:       return int'(n_execute_fields);
            3:       return int'(n_memory_fields);
            default: return int'(n_wb_fields);
        endcase
    endfunction

    // Stage code over field index for the k-th latch word
    function automatic logic [6:0] latch_select(input int k);
        int s;
        int rem;
        s = 0;
        rem = k;
        while (rem >= field_count(s))
        begin
            rem = rem - field_count(s);
            s = s + 1;
        end
        return {s[2:0], rem[3:0]};
    endfunction

    function automatic logic [31:0] expected_dump_word(input int idx);
        if (idx == 0)
            return pc_val;
        else if (idx < 1 + num_regs)
            return regs[idx - 1];
        else if (idx < latch_base)
            return mem_words[idx - 1 - num_regs];
        else
            return latch_tab[latch_select(idx - latch_base)];
    endfunction

    //////////////////////////////
    // Compare tasks
    //////////////////////////////
    task automatic check_word(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
        if (actual !== expected)
        begin
            err_count++;
            $display("FAILED at time %0t: %s expected %h, got %h", $time, name, expected, actual);
        end
    endtask

    task automatic check_bit(input string name, input logic expected, input logic actual);
        if (actual !== expected)
        begin
            err_count++;
            $display("FAILED at time %0t: %s expected %b, got %b", $time, name, expected, actual);
        end
    endtask

    task automatic check_state(input string name, input stage_t expected, input stage_t actual);
        if (actual !== expected)
        begin
            err_count++;
            $display("FAILED at time %0t: %s expected %0d, got %0d", $time, name, expected,
                     actual);
        end
    endtask

    //////////////////////////////
    // Host and monitors
    //////////////////////////////
    task automatic send_byte(input logic [7:0] value);
        rx <= 1'b0;
        repeat (clks_per_bit) @(posedge clk);
        for (int i = 0; i < 8; i++)
        begin
            rx <= value[i];
            repeat (clks_per_bit) @(posedge clk);
        end
        rx <= 1'b1;
        repeat (clks_per_bit) @(posedge clk);
    endtask

    task automatic send_word(input logic [31:0] value);
        for (int b = 3; b >= 0; b--)
            send_byte(value[b*8 +: 8]);
    endtask

    // Samples each tx bit near its middle
    initial
    begin : tx_monitor
        logic [7:0]  data_bits;
        logic [31:0] word;
        int          nbytes;
        nbytes = 0;
        word = '0;
        forever
        begin
            @(negedge clk);
            if (rst === 1'b0 && tx === 1'b0)
            begin
                repeat (clks_per_bit / 2) @(negedge clk);
                for (int i = 0; i < 8; i++)
                begin
                    repeat (clks_per_bit) @(negedge clk);
                    data_bits[i] = tx;
                end
                repeat (clks_per_bit) @(negedge clk);
                if (tx !== 1'b1)
                begin
                    fail_count++;
                    $display("Missing stop bit on tx at time %0t", $time);
                end
                word = {word[23:0], data_bits};
                nbytes++;
                if (nbytes == 4)
                begin
                    got_q.push_back(word);
                    nbytes = 0;
                end
            end
        end
    end

    always @(negedge clk)
    begin : compare_words
        logic [31:0] got_word;
        if (got_q.size() > 0)
        begin
            got_word = got_q.pop_front();
            if (exp_q.size() == 0)
            begin
                fail_count++;
                $display("Unexpected word %h received on tx at time %0t", got_word, $time);
            end
            else
                check_word("tx word", exp_q.pop_front(), got_word);
        end
    end

    always @(negedge clk)
    begin
        if (instr_we === 1'b1)
        begin
            wr_addr_q.push_back(instr_addr);
            wr_data_q.push_back(instr_data);
        end
        if (i_dut.tx_word_start === 1'b1)
        begin
            sel_q.push_back(latch_sel);
            act_q.push_back(debug_active);
        end
    end

    //////////////////////////////
    // Bounded waits
    //////////////////////////////
    task automatic wait_for_active(input logic level, input int limit, input string what);
        int n;
        n = 0;
        while (debug_active !== level && n < limit)
        begin
            @(negedge clk);
            n++;
        end
        if (debug_active !== level)
        begin
            fail_count++;
            timed_out = 1'b1;
            $display("Timeout after %0d cycles waiting for %s", limit, what);
        end
    endtask

    task automatic wait_for_writes(input int count, input int limit);
        int n;
        n = 0;
        while (wr_addr_q.size() < count && n < limit)
        begin
            @(negedge clk);
            n++;
        end
        if (wr_addr_q.size() < count)
        begin
            fail_count++;
            timed_out = 1'b1;
            $display("Timeout: only %0d of %0d instruction writes seen", wr_addr_q.size(), count);
        end
    endtask

    task automatic wait_for_drain(input int limit);
        int n;
        n = 0;
        while (exp_q.size() > 0 && n < limit)
        begin
            @(negedge clk);
            n++;
        end
        if (exp_q.size() > 0)
        begin
            fail_count++;
            timed_out = 1'b1;
            $display("Timeout: %0d dump words never arrived on tx", exp_q.size());
        end
    endtask

    //////////////////////////////
    // Test sequences
    //////////////////////////////
    task automatic run_load();
        logic [31:0] w;
        for (int i = 0; i < load_len - 1; i++)
        begin
            w = '0;
            while (w == '0)
                take_bits(32, w);
            sent_q.push_back(w);
        end
        sent_q.push_back(halt_word);
        @(posedge clk);
        for (int i = 0; i < load_len; i++)
            send_word(sent_q[i]);
        wait_for_writes(load_len, 40 * clks_per_bit);
        if (!timed_out)
        begin
            check_word("instr_we count", load_len, wr_addr_q.size());
            for (int i = 0; i < load_len; i++)
            begin
                check_word("instr_addr", i, wr_addr_q[i]);
                check_word("instr_data", sent_q[i], wr_data_q[i]);
            end
            check_bit("stall_pc", 1'b1, stall_pc);
            check_bit("debug_active", 1'b0, debug_active);
        end
    endtask

    task automatic run_dump();
        logic [31:0] request;
        logic [6:0]  exp_sel;
        sel_q.delete();
        act_q.delete();
        for (int i = 0; i < dump_len; i++)
            exp_q.push_back(expected_dump_word(i));
        take_bits(32, request);
        @(posedge clk);
        send_word(request);
        wait_for_active(1'b1, 40 * clks_per_bit, "dump start");
        if (!timed_out)
        begin
            check_bit("stall_pc", 1'b1, stall_pc);
            wait_for_active(1'b0, dump_len * 100 * clks_per_bit, "dump end");
        end
        if (!timed_out)
        begin
            // Stall is released together with debug_active
            check_bit("stall_pc", 1'b0, stall_pc);
            wait_for_drain(40 * clks_per_bit);
        end
        if (!timed_out)
        begin
            // Quiet line afterwards shows no extra words
            repeat (60 * clks_per_bit) @(negedge clk);
            check_word("tx_word_start count", dump_len, sel_q.size());
            for (int i = 0; i < act_q.size(); i++)
                check_bit("debug_active", 1'b1, act_q[i]);
            if (sel_q.size() >= dump_len)
            begin
                for (int k = 0; k < n_latch_fields; k++)
                begin
                    exp_sel = latch_select(k);
                    check_state("latch_sel stage", stage_t'(exp_sel[6:4]),
                                stage_t'(sel_q[latch_base + k][6:4]));
                    check_word("latch_sel field", exp_sel[3:0], sel_q[latch_base + k][3:0]);
                end
            end
        end
    endtask

    initial
    begin
        rst = 1'b1;
        rx = 1'b1;
        lfsr_state = 32'h1d7fd70e;
        fill_model();
        repeat (16) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        check_bit("stall_pc", 1'b1, stall_pc);
        check_bit("debug_active", 1'b0, debug_active);
        check_bit("instr_we", 1'b0, instr_we);
        check_bit("tx", 1'b1, tx);

        run_load();
        if (!timed_out)
            run_dump();
        if (!timed_out)
        begin
            fill_model();
            run_dump();
        end
        check_word("instr_we count after halt", load_len, wr_addr_q.size());

        $display("Run complete: %0d value mismatches, %0d other failures",
                 err_count, fail_count);
        if (err_count == 0 && fail_count == 0)
            $display("ALL CHECKS PASSED");
        else
            $display("CHECKS FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== uart_rx.sv ====
`timescale 1ns/1ps
`default_nettype none

module uart_rx #(
    parameter int clks_per_bit = 868
) (
    input  wire        clk,
    input  wire        rst,
    input  wire        rx,
    output logic [7:0] rx_byte,
    output logic       rx_byte_valid
);

    localparam int cnt_w = $clog2(clks_per_bit + 1);
    localparam logic [cnt_w-1:0] baud_last = cnt_w'(clks_per_bit - 1);
    localparam logic [cnt_w-1:0] half_last = cnt_w'(clks_per_bit / 2 - 1);

    typedef enum logic [1:0] {
        rx_idle,
        rx_start,
        rx_data,
        rx_stop
    } rx_state_t;

    rx_state_t        state;
    logic             rx_meta;
    logic             rx_sync;
    logic [cnt_w-1:0] baud_cnt;
    logic [2:0]       bit_cnt;

    // Two-flop synchronizer, line idles high
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
        end
        else
        begin
            rx_meta <= rx;
            rx_sync <= rx_meta;
        end
    end

    //////////////////////////////
    // Frame FSM
    //////////////////////////////
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            state         <= rx_idle;
            baud_cnt      <= '0;
            bit_cnt       <= '0;
            rx_byte_valid <= 1'b0;
        end
        else
        begin
            rx_byte_valid <= 1'b0;
            case (state)
                rx_idle:
                begin
                    baud_cnt <= '0;
                    if (!rx_sync)
                        state <= rx_start;
                end
                rx_start:
                begin
                    // Recheck the start bit at its middle
                    if (baud_cnt == half_last)
                    begin
                        baud_cnt <= '0;
                        bit_cnt  <= '0;
                        state    <= rx_sync ? rx_idle : rx_data;
                    end
                    else
                        baud_cnt <= baud_cnt + 1'b1;
                end
                rx_data:
                begin
                    if (baud_cnt == baud_last)
                    begin
                        baud_cnt <= '0;
                        bit_cnt  <= bit_cnt + 3'd1;
                        if (bit_cnt == 3'd7)
                            state <= rx_stop;
                    end
                    else
                        baud_cnt <= baud_cnt + 1'b1;
                end
                default:
                begin
                    if (baud_cnt == baud_last)
                    begin
                        rx_byte_valid <= rx_sync;
                        state         <= rx_idle;
                    end
                    else
                        baud_cnt <= baud_cnt + 1'b1;
                end
            endcase
        end
    end

    // Data bits arrive LSB first
    always_ff @(posedge clk)
    begin
        if (state == rx_data && baud_cnt == baud_last)
            rx_byte <= {rx_sync, rx_byte[7:1]};
    end

    assert property (@(posedge clk) disable iff (rst) rx_byte_valid |=> !rx_byte_valid)
        else $error("uart_rx: byte strobe longer than one cycle");

endmodule

`default_nettype wire

// ==== uart_tx.sv ====
`timescale 1ns/1ps
`default_nettype none

module uart_tx #(
    parameter int clks_per_bit = 868
) (
    input  wire        clk,
    input  wire        rst,
    input  wire        byte_start,
    input  wire  [7:0] tx_byte,
    output logic       tx,
    output logic       tx_busy,
    output logic       byte_done
);

    localparam int cnt_w = $clog2(clks_per_bit + 1);
    localparam logic [cnt_w-1:0] baud_last = cnt_w'(clks_per_bit - 1);

    logic [cnt_w-1:0] baud_cnt;
    logic [3:0]       bit_cnt;
    // Stop bit above the data bits
    logic [8:0]       shreg;

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            tx        <= 1'b1;
            tx_busy   <= 1'b0;
            byte_done <= 1'b0;
            baud_cnt  <= '0;
            bit_cnt   <= '0;
        end
        else
        begin
            byte_done <= 1'b0;
            if (!tx_busy)
            begin
                if (byte_start)
                begin
                    // Start bit
                    tx       <= 1'b0;
                    tx_busy  <= 1'b1;
                    baud_cnt <= '0;
                    bit_cnt  <= '0;
                end
            end
            else if (baud_cnt == baud_last)
            begin
                baud_cnt <= '0;
                if (bit_cnt == 4'd9)
                begin
                    tx_busy   <= 1'b0;
                    byte_done <= 1'b1;
                end
                else
                begin
                    tx      <= shreg[0];
                    bit_cnt <= bit_cnt + 4'd1;
                end
            end
            else
                baud_cnt <= baud_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk)
    begin
        if (byte_start && !tx_busy)
            shreg <= {1'b1, tx_byte};
        else if (tx_busy && baud_cnt == baud_last)
            shreg <= {1'b1, shreg[8:1]};
    end

    assert property (@(posedge clk) disable iff (rst) byte_start |-> !tx_busy)
        else $error("uart_tx: byte_start while a byte is in flight");

endmodule

`default_nettype wire

// ==== uart_word_link.sv ====
`timescale 1ns/1ps
`default_nettype none

module uart_word_link import dbg_pkg::*; #(
    parameter int clks_per_bit = 868
) (
    input  wire                   clk,
    input  wire                   rst,
    input  wire                   rx,
    output logic                  tx,
    output logic [word_width-1:0] rx_word,
    output logic                  rx_word_valid,
    input  wire  [word_width-1:0] tx_word,
    input  wire                   tx_word_start,
    output logic                  tx_word_done
);

    logic [7:0]            rx_byte;
    logic                  rx_byte_valid;
    logic [1:0]            rx_cnt;

    logic [7:0]            tx_byte;
    logic                  byte_start;
    logic                  byte_done;
    logic                  tx_busy;
    logic                  tx_active;
    logic [1:0]            tx_idx;
    logic [word_width-1:0] tx_shift;

    uart_rx #(
        .clks_per_bit (clks_per_bit)
    ) i_uart_rx (
        .clk           (clk),
        .rst           (rst),
        .rx            (rx),
        .rx_byte       (rx_byte),
        .rx_byte_valid (rx_byte_valid)
    );

    uart_tx #(
        .clks_per_bit (clks_per_bit)
    ) i_uart_tx (
        .clk        (clk),
        .rst        (rst),
        .byte_start (byte_start),
        .tx_byte    (tx_byte),
        .tx         (tx),
        .tx_busy    (tx_busy),
        .byte_done  (byte_done)
    );

    //////////////////////////////
    // Receive, MSB byte first
    //////////////////////////////
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            rx_cnt        <= '0;
            rx_word_valid <= 1'b0;
        end
        else
        begin
            rx_word_valid <= rx_byte_valid && rx_cnt == 2'd3;
            if (rx_byte_valid)
                rx_cnt <= rx_cnt + 2'd1;
        end
    end

    always_ff @(posedge clk)
    begin
        if (rx_byte_valid)
            rx_word <= {rx_word[word_width-9:0], rx_byte};
    end

    //////////////////////////////
    // Transmit, MSB byte first
    //////////////////////////////
    assign tx_byte = tx_shift[word_width-1 -: 8];

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            tx_active    <= 1'b0;
            tx_idx       <= '0;
            byte_start   <= 1'b0;
            tx_word_done <= 1'b0;
        end
        else
        begin
            byte_start   <= 1'b0;
            tx_word_done <= 1'b0;
            if (tx_word_start)
            begin
                tx_active  <= 1'b1;
                tx_idx     <= '0;
                byte_start <= 1'b1;
            end
            else if (tx_active && byte_done)
            begin
                if (tx_idx == 2'd3)
                begin
                    tx_active    <= 1'b0;
                    tx_word_done <= 1'b1;
                end
                else
                begin
                    tx_idx     <= tx_idx + 2'd1;
                    byte_start <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (tx_word_start)
            tx_shift <= tx_word;
        else if (tx_active && byte_done)
            tx_shift <= {tx_shift[word_width-9:0], 8'h00};
    end

    // A new word only once the previous one has fully left
    assert property (@(posedge clk) disable iff (rst) tx_word_start |-> !tx_active && !tx_busy)
        else $error("uart_word_link: tx_word_start in the middle of a word");

endmodule

`default_nettype wire
